// ==== common/rf_pkg.sv ====
package rf_pkg;

    // ------------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------------

    // Number of words held by the register file
    localparam int RF_DEPTH = 64;

    // Address width needed to reach every word
    localparam int RF_ADDR_W = 6;

    // Width of one stored word, without the padding bit of the hard macro
    localparam int RF_DATA_W = 27;

    // ------------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------------

    // Number of rclk edges from the first edge that sees the power request
    // until the array counts as powered
    localparam int PWR_WAKE_CYCLES = 4;

    // Width of the wake counter, wide enough to hold PWR_WAKE_CYCLES
    localparam int PWR_CNT_W = $clog2(PWR_WAKE_CYCLES + 1);

    // States of the power controller
    // PG_OFF   array unpowered, contents lost, outputs forced low
    // PG_WAKE  power switches ramping, array not yet usable
    // PG_ON    array powered, reads and writes accepted
    typedef enum logic [1:0] {
        PG_OFF  = 2'd0,
        PG_WAKE = 2'd1,
        PG_ON   = 2'd2
    } pg_state_t;

endpackage

// ==== compile.f ====
common/rf_pkg.sv
source/mem_reset_sync.sv
rf_array/rf_power_ctl.sv
rf_array/rf_array_2p.sv
source/rf_pg_64x27.sv
verif/rf_pg_64x27_chk.sv
verif/tb_rf_pg_64x27.sv

// ==== rf_array/rf_array_2p.sv ====
`timescale 1ns/1ns

module rf_array_2p
    import rf_pkg::*;
(
    input  logic                 wclk,
    input  logic                 rclk,
    input  logic                 rst_n,
    input  logic                 ip_reset_b_sync,
    input  logic                 we,
    input  logic [RF_ADDR_W-1:0] waddr,
    input  logic [RF_DATA_W-1:0] wdata,
    input  logic                 re,
    input  logic [RF_ADDR_W-1:0] raddr,
    input  logic                 pwr_on,
    input  logic                 pwr_off_pulse,
    input  logic                 pgcb_isol_en,
    output logic [RF_DATA_W-1:0] rdata
);

    // Storage cells, one entry per word
    logic [RF_DATA_W-1:0] mem_q [RF_DEPTH];

    // Word captured by the last accepted read
    logic [RF_DATA_W-1:0] rd_q;

    // High when the output must be driven to zero
    logic out_force;

    // ------------------------------------------------------------------
    // Write stage
    // ------------------------------------------------------------------

    // Contents do not survive a power-down, so the array is zeroed when the
    // controller announces the loss, and also on the global reset
    // Writes only land while the array is powered
    always_ff @(posedge wclk) begin
        if (!rst_n || pwr_off_pulse) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we && pwr_on) begin
            mem_q[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------
    // Read stage
    // ------------------------------------------------------------------

    // One cycle of latency, the held word stays until the next accepted read
    // A read and a write to the same address on one edge see the old word,
    // because the storage update and this capture happen on the same edge
    always_ff @(posedge rclk) begin
        if (!rst_n || !ip_reset_b_sync) begin
            // The ip reset only touches the output register, never the cells
            rd_q <= '0;
        end else if (re) begin
            if (pwr_on) begin
                rd_q <= mem_q[raddr];
            end else begin
                // An unpowered array has nothing to return
                rd_q <= '0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output forcing
    // ------------------------------------------------------------------

    // Isolation clamps the output while the domain is being switched, and an
    // array that is not powered also presents zero
    // rd_q is left alone so the held word comes back when isolation ends
    assign out_force = pgcb_isol_en || !pwr_on;

    assign rdata = out_force ? '0 : rd_q;

endmodule

// ==== rf_array/rf_power_ctl.sv ====
`timescale 1ns/1ns

module rf_power_ctl
    import rf_pkg::*;
(
    input  logic rclk,
    input  logic rst_n,
    input  logic pwr_enable_b_in,
    output logic pwr_on,
    output logic pwr_off_pulse,
    output logic pwr_enable_b_out
);

    // Current and next power state
    pg_state_t state_q;
    pg_state_t state_d;

    // Counts the edges spent ramping the power switches
    logic [PWR_CNT_W-1:0] wake_cnt_q;
    logic [PWR_CNT_W-1:0] wake_cnt_d;

    // Registered strobe that tells the array its contents are gone
    logic off_pulse_q;

    // ------------------------------------------------------------------
    // Next-state logic
    // ------------------------------------------------------------------

    // The wake sequence models a chain of staged power switches, each
    // stage closing one edge after the previous one
    always_comb begin
        state_d    = state_q;
        wake_cnt_d = '0;
        unique case (state_q)
            PG_OFF: begin
                // The first edge that sees the low request counts as
                // the first step of the wake sequence
                if (!pwr_enable_b_in) begin
                    state_d    = PG_WAKE;
                    wake_cnt_d = PWR_CNT_W'(1);
                end
            end
            PG_WAKE: begin
                if (pwr_enable_b_in) begin
                    // Request withdrawn before the ramp completed
                    state_d = PG_OFF;
                end else if (wake_cnt_q == PWR_CNT_W'(PWR_WAKE_CYCLES - 1)) begin
                    state_d = PG_ON;
                end else begin
                    wake_cnt_d = wake_cnt_q + 1'b1;
                end
            end
            PG_ON: begin
                // Power is removed on the very next edge, no ramp down
                if (pwr_enable_b_in) begin
                    state_d = PG_OFF;
                end
            end
            default: begin
                state_d = PG_OFF;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------------

    always_ff @(posedge rclk) begin
        if (!rst_n) begin
            state_q     <= PG_OFF;
            wake_cnt_q  <= '0;
            off_pulse_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            wake_cnt_q <= wake_cnt_d;
            // Fires on the same edge that leaves PG_ON, so the array learns
            // about the loss exactly once per power-down
            off_pulse_q <= (state_q == PG_ON) && pwr_enable_b_in;
        end
    end

    // Outputs decode the state directly
    assign pwr_on           = (state_q == PG_ON);
    assign pwr_enable_b_out = ~pwr_on;
    assign pwr_off_pulse    = off_pulse_q;

endmodule

// ==== source/mem_reset_sync.sv ====
`timescale 1ns/1ns

module mem_reset_sync (
    input  logic rclk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    // Two synchronizer stages, the second one feeds the read path
    logic [1:0] sync_q;

    // ------------------------------------------------------------------
    // Synchronizer
    // ------------------------------------------------------------------

    // The ip reset may arrive at any time relative to rclk, so assertion
    // takes effect at once and only the release is retimed
    // Release ripples through both stages, giving two rclk edges of
    // settling before the read stage leaves reset
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // ------------------------------------------------------------------
    // Scan bypass
    // ------------------------------------------------------------------

    // In scan mode the tester owns the reset directly, so the bypass value
    // replaces the synchronized one
    always_comb begin
        if (fscan_rstbypen) begin
            rst_n_sync = fscan_byprst_b;
        end else begin
            rst_n_sync = sync_q[1];
        end
    end

endmodule

// ==== source/rf_pg_64x27.sv ====
`timescale 1ns/1ns

module rf_pg_64x27
    import rf_pkg::*;
(
    // Write port
    input  logic                 wclk,
    input  logic                 rst_n,
    input  logic                 we,
    input  logic [RF_ADDR_W-1:0] waddr,
    input  logic [RF_DATA_W-1:0] wdata,

    // Read port
    input  logic                 rclk,
    input  logic                 re,
    input  logic [RF_ADDR_W-1:0] raddr,
    output logic [RF_DATA_W-1:0] rdata,

    // Power interface
    input  logic                 pgcb_isol_en,
    input  logic                 pwr_enable_b_in,
    output logic                 pwr_enable_b_out,

    // ip reset and its scan bypass
    input  logic                 ip_reset_b,
    input  logic                 fscan_byprst_b,
    input  logic                 fscan_rstbypen
);

    // ip reset after retiming onto rclk
    logic ip_reset_b_sync;

    // Power state as seen by the array
    logic pwr_on;
    logic pwr_off_pulse;

    // ------------------------------------------------------------------
    // ip reset synchronizer
    // ------------------------------------------------------------------

    // Only the read stage uses the ip reset, so it is retimed to rclk
    mem_reset_sync i_ip_reset_b_sync (
        .rclk           (rclk),
        .rst_n          (ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (ip_reset_b_sync)
    );

    // ------------------------------------------------------------------
    // Power controller
    // ------------------------------------------------------------------

    // Sequences the wake-up on rclk and reports the result back out
    rf_power_ctl i_rf_power_ctl (
        .rclk             (rclk),
        .rst_n            (rst_n),
        .pwr_enable_b_in  (pwr_enable_b_in),
        .pwr_on           (pwr_on),
        .pwr_off_pulse    (pwr_off_pulse),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

    // ------------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------------

    // Isolation comes straight from the power-gating controller outside
    rf_array_2p i_rf_array_2p (
        .wclk            (wclk),
        .rclk            (rclk),
        .rst_n           (rst_n),
        .ip_reset_b_sync (ip_reset_b_sync),
        .we              (we),
        .waddr           (waddr),
        .wdata           (wdata),
        .re              (re),
        .raddr           (raddr),
        .pwr_on          (pwr_on),
        .pwr_off_pulse   (pwr_off_pulse),
        .pgcb_isol_en    (pgcb_isol_en),
        .rdata           (rdata)
    );

endmodule

// ==== verif/rf_pg_64x27_chk.sv ====
`timescale 1ns/1ns

module rf_pg_64x27_chk
    import rf_pkg::*;
(
    input logic                 rclk,
    input logic                 rst_n,
    input logic                 pgcb_isol_en,
    input logic                 pwr_enable_b_in,
    input logic                 pwr_enable_b_out,
    input logic [RF_DATA_W-1:0] rdata
);

    // ------------------------------------------------------------------
    // Output forcing
    // ------------------------------------------------------------------

    // An isolated or unpowered array must never leak a stored word
    forced_rdata_zero : assert property (
        @(posedge rclk) disable iff (!rst_n)
        (pgcb_isol_en || pwr_enable_b_out) |-> (rdata == '0)
    ) else $error("rdata is not zero while isolated or powered off");

    // ------------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------------

    // Power removal takes effect on the first edge, with no ramp down
    fast_power_off : assert property (
        @(posedge rclk) disable iff (!rst_n)
        $rose(pwr_enable_b_in) |=> pwr_enable_b_out
    ) else $error("pwr_enable_b_out did not rise one cycle after the power-off request");

    // The synchronous reset parks the controller in its off state
    off_in_reset : assert property (
        @(posedge rclk)
        !rst_n |=> pwr_enable_b_out
    ) else $error("pwr_enable_b_out is low while rst_n is asserted");

endmodule

// Attach the checker to every instance of the top level
bind rf_pg_64x27 rf_pg_64x27_chk i_rf_pg_64x27_chk (
    .rclk             (rclk),
    .rst_n            (rst_n),
    .pgcb_isol_en     (pgcb_isol_en),
    .pwr_enable_b_in  (pwr_enable_b_in),
    .pwr_enable_b_out (pwr_enable_b_out),
    .rdata            (rdata)
);

// ==== verif/tb_rf_pg_64x27.sv ====
`timescale 1ns/1ns

module tb_rf_pg_64x27
    import rf_pkg::*;
();

    // Operations that one table row can apply in one clock cycle
    typedef enum logic [3:0] {
        OP_IDLE, OP_WRITE, OP_READ, OP_READ_WRITE, OP_PWR_OFF,
        OP_PWR_ON, OP_ISOL_ON, OP_ISOL_OFF, OP_IP_RESET
    } op_t;

    // One stimulus row, exp_fixed marks rows whose rdata is known in advance
    typedef struct packed {
        op_t                  op;
        logic [RF_ADDR_W-1:0] addr;
        logic [RF_DATA_W-1:0] data;
        logic                 exp_fixed;
        logic [RF_DATA_W-1:0] exp_rdata;
    } row_t;

    // Single clock drives both ports
    logic clk = 1'b0;

    // DUT inputs and outputs
    logic                 rst_n;
    logic                 we;
    logic [RF_ADDR_W-1:0] waddr;
    logic [RF_DATA_W-1:0] wdata;
    logic                 re;
    logic [RF_ADDR_W-1:0] raddr;
    logic [RF_DATA_W-1:0] rdata;
    logic                 pgcb_isol_en;
    logic                 pwr_enable_b_in;
    logic                 pwr_enable_b_out;
    logic                 ip_reset_b;
    logic                 fscan_byprst_b;
    logic                 fscan_rstbypen;

    // Stimulus table and random state
    row_t        stim_table[$];
    logic [31:0] lcg_state = 32'h38d7_c9dc;

    // Reference model of the register file
    logic [RF_DATA_W-1:0] ref_mem [RF_DEPTH];
    logic [RF_DATA_W-1:0] ref_held;
    logic                 ref_pwr;
    logic                 ref_isol;
    int                   ip_hold;

    always #20 clk = ~clk;

    rf_pg_64x27 i_rf_pg_64x27 (
        .wclk             (clk),
        .rst_n            (rst_n),
        .we               (we),
        .waddr            (waddr),
        .wdata            (wdata),
        .rclk             (clk),
        .re               (re),
        .raddr            (raddr),
        .rdata            (rdata),
        .pgcb_isol_en     (pgcb_isol_en),
        .pwr_enable_b_in  (pwr_enable_b_in),
        .pwr_enable_b_out (pwr_enable_b_out),
        .ip_reset_b       (ip_reset_b),
        .fscan_byprst_b   (fscan_byprst_b),
        .fscan_rstbypen   (fscan_rstbypen)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Numerical Recipes constants, a full-period 32-bit generator
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input op_t op, input int addr, input logic [RF_DATA_W-1:0] data,
                           input logic exp_fixed, input logic [RF_DATA_W-1:0] exp_rdata);
        row_t row;
        row.op        = op;
        row.addr      = RF_ADDR_W'(addr);
        row.data      = data;
        row.exp_fixed = exp_fixed;
        row.exp_rdata = exp_rdata;
        stim_table.push_back(row);
    endtask

    // Draws the next random word, upper bits have the better period
    task automatic next_word(output logic [RF_DATA_W-1:0] word);
        lcg_state = lcg_next(lcg_state);
        word      = lcg_state[31:32-RF_DATA_W];
    endtask

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------

    task automatic build_table();
        logic [RF_DATA_W-1:0] word;
        // Wake the array, storage must come up empty after reset
        add_row(OP_PWR_ON, 0, '0, 1'b1, '0);
        for (int a = 0; a < 4; a++) begin
            add_row(OP_READ, a * 21, '0, 1'b1, '0);
        end
        // Fill every word, then read back in a scrambled order
        // An idle row after each read shows that rdata holds
        for (int a = 0; a < RF_DEPTH; a++) begin
            next_word(word);
            add_row(OP_WRITE, a, word, 1'b0, '0);
        end
        for (int a = 0; a < RF_DEPTH; a++) begin
            add_row(OP_READ, (a * 37 + 11) % RF_DEPTH, '0, 1'b0, '0);
            add_row(OP_IDLE, 0, '0, 1'b0, '0);
        end
        // Read and write of one address on the same edge sees the old word
        next_word(word);
        add_row(OP_READ_WRITE, 10, word, 1'b0, '0);
        add_row(OP_READ, 10, '0, 1'b1, word);
        // Isolation clamps the output but leaves held word and storage alone
        add_row(OP_READ, 20, '0, 1'b0, '0);
        add_row(OP_ISOL_ON, 0, '0, 1'b1, '0);
        add_row(OP_READ, 33, '0, 1'b1, '0);
        add_row(OP_ISOL_OFF, 0, '0, 1'b0, '0);
        add_row(OP_READ, 20, '0, 1'b0, '0);
        add_row(OP_READ, 33, '0, 1'b0, '0);
        // Power cycle loses all contents and ignores writes while off
        // The write lands after the clear strobe, so only the power gating can stop it
        next_word(word);
        add_row(OP_PWR_OFF, 0, '0, 1'b1, '0);
        add_row(OP_IDLE, 0, '0, 1'b1, '0);
        add_row(OP_WRITE, 7, word, 1'b1, '0);
        add_row(OP_READ, 3, '0, 1'b1, '0);
        add_row(OP_PWR_ON, 0, '0, 1'b1, '0);
        for (int a = 0; a < RF_DEPTH; a++) begin
            add_row(OP_READ, a, '0, 1'b1, '0);
        end
        // ip reset clears only the held word
        for (int a = 40; a < 44; a++) begin
            next_word(word);
            add_row(OP_WRITE, a, word, 1'b0, '0);
        end
        add_row(OP_READ, 41, '0, 1'b0, '0);
        add_row(OP_IP_RESET, 0, '0, 1'b1, '0);
        add_row(OP_IDLE, 0, '0, 1'b1, '0);
        add_row(OP_IDLE, 0, '0, 1'b1, '0);
        for (int a = 40; a < 44; a++) begin
            add_row(OP_READ, a, '0, 1'b0, '0);
        end
    endtask

    // ------------------------------------------------------------------
    // Driving, waiting and the reference model
    // ------------------------------------------------------------------

    // Strobes last one cycle, power and isolation levels persist
    task automatic drive_row(input row_t row);
        we         = 1'b0;
        re         = 1'b0;
        ip_reset_b = 1'b1;
        case (row.op)
            OP_WRITE: begin
                we    = 1'b1;
                waddr = row.addr;
                wdata = row.data;
            end
            OP_READ: begin
                re    = 1'b1;
                raddr = row.addr;
            end
            OP_READ_WRITE: begin
                we    = 1'b1;
                re    = 1'b1;
                waddr = row.addr;
                raddr = row.addr;
                wdata = row.data;
            end
            OP_PWR_OFF:  pwr_enable_b_in = 1'b1;
            OP_PWR_ON:   pwr_enable_b_in = 1'b0;
            OP_ISOL_ON:  pgcb_isol_en = 1'b1;
            OP_ISOL_OFF: pgcb_isol_en = 1'b0;
            OP_IP_RESET: ip_reset_b = 1'b0;
            default: begin
            end
        endcase
    endtask

    // Counts edges from the request until power is reported on
    task automatic wait_power_on();
        int edges;
        edges = 0;
        while (pwr_enable_b_out !== 1'b0) begin
            if (edges >= 20) begin
                $display("Power never came on: pwr_enable_b_out high after %0d cycles", edges);
                $display("ERRORS FOUND");
                $fatal(1, "Timeout while waiting for power on");
            end
            @(posedge clk);
            #1;
            edges++;
        end
        check_value("wake cycles", edges, PWR_WAKE_CYCLES);
    endtask

    // Advances the model by one edge, the read sees storage before the write
    task automatic update_model(input row_t row);
        if (row.op == OP_IP_RESET) begin
            ref_held = '0;
            ip_hold  = 2;
        end else if (ip_hold > 0) begin
            // Synchronizer still releasing, the read register stays cleared
            ref_held = '0;
            ip_hold--;
        end else if (row.op == OP_READ || row.op == OP_READ_WRITE) begin
            ref_held = ref_pwr ? ref_mem[row.addr] : '0;
        end
        if ((row.op == OP_WRITE || row.op == OP_READ_WRITE) && ref_pwr) begin
            ref_mem[row.addr] = row.data;
        end
        case (row.op)
            OP_PWR_OFF: begin
                ref_pwr = 1'b0;
                for (int a = 0; a < RF_DEPTH; a++) begin
                    ref_mem[a] = '0;
                end
            end
            OP_PWR_ON:   ref_pwr = 1'b1;
            OP_ISOL_ON:  ref_isol = 1'b1;
            OP_ISOL_OFF: ref_isol = 1'b0;
            default: begin
            end
        endcase
    endtask

    task automatic check_row(input row_t row);
        logic [RF_DATA_W-1:0] expected;
        expected = (ref_isol || !ref_pwr) ? '0 : ref_held;
        check_value("rdata", rdata, expected);
        if (row.exp_fixed) begin
            check_value("rdata", rdata, row.exp_rdata);
        end
        check_value("pwr_enable_b_out", pwr_enable_b_out, !ref_pwr);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        rst_n           = 1'b0;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b1;
        ip_reset_b      = 1'b0;
        fscan_byprst_b  = 1'b1;
        fscan_rstbypen  = 1'b0;
        for (int a = 0; a < RF_DEPTH; a++) begin
            ref_mem[a] = '0;
        end
        ref_held = '0;
        ref_pwr  = 1'b0;
        ref_isol = 1'b0;
        ip_hold  = 0;
        build_table();

        // The ip reset is released early so its synchronizer is settled
        repeat (2) @(posedge clk);
        #2;
        ip_reset_b = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Straight out of reset the array is off and silent
        @(posedge clk);
        #1;
        check_value("rdata", rdata, '0);
        check_value("pwr_enable_b_out", pwr_enable_b_out, 1'b1);
        #1;

        // Every row is driven 2 ns after an edge and checked 1 ns after the next
        for (int i = 0; i < stim_table.size(); i++) begin
            drive_row(stim_table[i]);
            if (stim_table[i].op == OP_PWR_ON) begin
                wait_power_on();
            end
            @(posedge clk);
            #1;
            update_model(stim_table[i]);
            check_row(stim_table[i]);
            #1;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
